// ==== Makefile ====
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= lsu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless the pass message is logged"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) tests/lsu_tb_model.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "TEST PASSED"; \
	else \
		echo "TEST FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== lsu.f ====
+incdir+tests
src/lsu_pkg.sv
src/lsu_req_stage.sv
src/lsu_byte_bank.sv
src/lsu_load_align.sv
src/lsu_top.sv
tests/lsu_tb.sv

// ==== src/lsu_byte_bank.sv ====
//////////////////////////////////////////////////
// Byte lane RAM bank
// Holds one byte of every data word, with a
// synchronous write and a registered read
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_byte_bank #(
   parameter int MEM_WORDS = 64
) (
   input  logic                         clk,
   input  logic                         stall,
   input  logic                         we,
   input  logic [$clog2(MEM_WORDS)-1:0] idx,
   input  lsu_pkg::lsu_byte_t           wdata,
   output lsu_pkg::lsu_byte_t           rdata
);
   import lsu_pkg::*;

   lsu_byte_t mem [MEM_WORDS];   // Contents undefined at power up

   // Frozen pipe means no write and a held read byte
   always_ff @(posedge clk) begin
      if (!stall) begin
         if (we) begin
            mem[idx] <= wdata;
         end
         rdata <= mem[idx];   // Old byte on a write cycle
      end
   end

   // Index comes from the stage 1 address register
   a_idx_known: assert property (@(posedge clk)
      we |-> !$isunknown(idx))
      else $error("bank write with unknown index");

endmodule

`default_nettype wire

// ==== src/lsu_load_align.sv ====
//////////////////////////////////////////////////
// Load align stage
// Carries the response fields, picks the byte
// or halfword out of the read word and extends
// it to a full data word
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               stall,
   input  logic               s1_valid,
   input  logic               s1_ealign,
   input  lsu_pkg::lsu_size_t s1_size,
   input  logic               s1_sign_ext,
   input  lsu_pkg::lsu_addr_t s1_addr,
   input  lsu_pkg::lsu_data_t rdata,
   output logic               resp_valid,
   output logic               resp_ealign,
   output lsu_pkg::lsu_addr_t resp_vaddr,
   output lsu_pkg::lsu_data_t resp_dout
);
   import lsu_pkg::*;

   lsu_size_t   s2_size;
   logic        s2_sign_ext;
   lsu_byte_t   dout_8b;
   logic [15:0] dout_16b;

   // Control bits, exception only for a live item
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         resp_valid  <= 1'b0;
         resp_ealign <= 1'b0;
      end else if (!stall) begin
         resp_valid  <= s1_valid;
         resp_ealign <= s1_valid & s1_ealign;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         s2_size     <= s1_size;
         s2_sign_ext <= s1_sign_ext;
         resp_vaddr  <= s1_addr;
      end
   end

   // Byte lane chosen by the two low address bits
   always_comb begin
      case (resp_vaddr[1:0])
         2'b00:   dout_8b = rdata[7:0];
         2'b01:   dout_8b = rdata[15:8];
         2'b10:   dout_8b = rdata[23:16];
         default: dout_8b = rdata[31:24];
      endcase
   end

   assign dout_16b = resp_vaddr[1] ? rdata[31:16] : rdata[15:0];

   always_comb begin
      case (s2_size)
         SIZE_BYTE: resp_dout = {{(DATA_W-8){s2_sign_ext & dout_8b[7]}}, dout_8b};
         SIZE_HALF: resp_dout = {{(DATA_W-16){s2_sign_ext & dout_16b[15]}}, dout_16b};
         SIZE_WORD: resp_dout = rdata;   // Full word untouched
         default:   resp_dout = '0;
      endcase
   end

   // An exception is only ever reported with its response
   a_ealign_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
      resp_ealign |-> resp_valid)
      else $error("alignment exception without a response");

endmodule

`default_nettype wire

// ==== src/lsu_pkg.sv ====
//////////////////////////////////////////////////
// Load/store unit common definitions
// Data path widths, byte lane count and the
// access size encoding shared by every stage
//////////////////////////////////////////////////

`default_nettype none

package lsu_pkg;

   localparam int DATA_W = 32;              // CPU data word
   localparam int LANE_W = 8;               // One byte lane
   localparam int LANES  = DATA_W / LANE_W;
   localparam int ADDR_W = 16;              // Byte address into local memory

   // Payload vectors
   typedef logic [DATA_W-1:0] lsu_data_t;
   typedef logic [ADDR_W-1:0] lsu_addr_t;
   typedef logic [LANE_W-1:0] lsu_byte_t;

   // Byte enables, bit i drives lane i
   typedef logic [LANES-1:0]  lsu_mask_t;

   // Access size as carried in the opcode size field
   // Value 0 is never issued by the decoder
   typedef enum logic [2:0] {
      SIZE_BYTE = 3'd1,
      SIZE_HALF = 3'd2,
      SIZE_WORD = 3'd3
   } lsu_size_t;

endpackage

`default_nettype wire

// ==== src/lsu_req_stage.sv ====
//////////////////////////////////////////////////
// Load/store request stage
// Decodes the access, checks alignment, builds
// the store lane data and byte mask, and holds
// the request for one enabled cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_req_stage #(
   parameter int MEM_WORDS = 64
) (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         stall,
   input  logic                         flush,
   input  logic                         req_valid,
   input  logic                         req_load,
   input  logic                         req_store,
   input  logic                         req_sign_ext,
   input  lsu_pkg::lsu_size_t           req_size,
   input  lsu_pkg::lsu_addr_t           req_addr,
   input  lsu_pkg::lsu_data_t           req_wdata,
   output logic                         s1_valid,
   output logic                         s1_ealign,
   output lsu_pkg::lsu_size_t           s1_size,
   output logic                         s1_sign_ext,
   output lsu_pkg::lsu_addr_t           s1_addr,
   output lsu_pkg::lsu_mask_t           bank_we,
   output lsu_pkg::lsu_data_t           bank_wdata,
   output logic [$clog2(MEM_WORDS)-1:0] bank_idx
);
   import lsu_pkg::*;

   localparam int IDX_W = $clog2(MEM_WORDS);

   logic      req_take;   // Real load or store offered
   logic      misalign;
   lsu_mask_t mask_byte;
   lsu_mask_t mask_half;
   lsu_mask_t lane_mask;
   lsu_data_t lane_data;
   logic      s1_store;
   lsu_mask_t s1_mask;

   // Neither load nor store means nothing to do
   assign req_take = req_valid & (req_load | req_store);

   // Word needs both low bits clear, halfword only bit 0
   assign misalign = ((req_size == SIZE_WORD) & (|req_addr[1:0])) |
                     ((req_size == SIZE_HALF) & req_addr[0]);

   assign mask_byte = lsu_mask_t'(1) << req_addr[1:0];
   assign mask_half = req_addr[1] ? 4'b1100 : 4'b0011;

   // Store data replicated so every enabled lane sees its byte
   always_comb begin
      case (req_size)
         SIZE_BYTE: begin
            lane_mask = mask_byte;
            lane_data = {LANES{req_wdata[7:0]}};
         end
         SIZE_HALF: begin
            lane_mask = mask_half;
            lane_data = {(LANES/2){req_wdata[15:0]}};
         end
         SIZE_WORD: begin
            lane_mask = '1;
            lane_data = req_wdata;
         end
         default: begin
            lane_mask = '0;         // Unknown size writes no lane
            lane_data = req_wdata;
         end
      endcase
   end

   // Flush drops stage 1 even when the pipe is frozen
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s1_valid <= 1'b0;
      end else if (flush) begin
         s1_valid <= 1'b0;
      end else if (!stall) begin
         s1_valid <= req_take;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         s1_ealign   <= misalign;
         s1_size     <= req_size;
         s1_sign_ext <= req_sign_ext;
         s1_addr     <= req_addr;
         s1_store    <= req_store;
         s1_mask     <= lane_mask;
         bank_wdata  <= lane_data;
      end
   end

   // Write only for a live, aligned store
   assign bank_we  = {LANES{s1_valid & s1_store & ~s1_ealign}} & s1_mask;
   assign bank_idx = s1_addr[2 +: IDX_W];   // Upper bits alias

   a_req_size_known: assert property (@(posedge clk) disable iff (!rst_n)
      (req_take && !stall && !flush) |-> (req_size inside {SIZE_BYTE, SIZE_HALF, SIZE_WORD}))
      else $error("request accepted with undefined size %0d", req_size);

   // Misaligned store must never reach the banks
   a_no_misaligned_write: assert property (@(posedge clk) disable iff (!rst_n)
      s1_ealign |-> (bank_we == '0))
      else $error("bank write enabled for a misaligned access");

endmodule

`default_nettype wire

// ==== src/lsu_top.sv ====
//////////////////////////////////////////////////
// Pipelined load/store unit
// Request stage, four byte lane banks as the
// local data memory, and the load align stage
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
   parameter int MEM_WORDS = 64
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               stall,
   input  logic               flush,
   input  logic               req_valid,
   input  logic               req_load,
   input  logic               req_store,
   input  logic               req_sign_ext,
   input  lsu_pkg::lsu_size_t req_size,
   input  lsu_pkg::lsu_addr_t req_addr,
   input  lsu_pkg::lsu_data_t req_wdata,
   output logic               resp_valid,
   output logic               resp_ealign,
   output lsu_pkg::lsu_addr_t resp_vaddr,
   output lsu_pkg::lsu_data_t resp_dout
);
   import lsu_pkg::*;

   localparam int IDX_W = $clog2(MEM_WORDS);

   // Stage 1 to stage 2
   logic      s1_valid;
   logic      s1_ealign;
   lsu_size_t s1_size;
   logic      s1_sign_ext;
   lsu_addr_t s1_addr;

   // Bank side
   lsu_mask_t        bank_we;
   lsu_data_t        bank_wdata;
   logic [IDX_W-1:0] bank_idx;
   lsu_data_t        bank_rdata;

   lsu_req_stage #(
      .MEM_WORDS (MEM_WORDS)
   ) u_req_stage (
      .clk          (clk),
      .rst_n        (rst_n),
      .stall        (stall),
      .flush        (flush),
      .req_valid    (req_valid),
      .req_load     (req_load),
      .req_store    (req_store),
      .req_sign_ext (req_sign_ext),
      .req_size     (req_size),
      .req_addr     (req_addr),
      .req_wdata    (req_wdata),
      .s1_valid     (s1_valid),
      .s1_ealign    (s1_ealign),
      .s1_size      (s1_size),
      .s1_sign_ext  (s1_sign_ext),
      .s1_addr      (s1_addr),
      .bank_we      (bank_we),
      .bank_wdata   (bank_wdata),
      .bank_idx     (bank_idx)
   );

   // One bank per byte lane, all sharing the word index
   for (genvar i = 0; i < LANES; i++) begin : g_lane
      lsu_byte_bank #(
         .MEM_WORDS (MEM_WORDS)
      ) u_bank (
         .clk   (clk),
         .stall (stall),
         .we    (bank_we[i]),
         .idx   (bank_idx),
         .wdata (bank_wdata[8*i +: 8]),
         .rdata (bank_rdata[8*i +: 8])
      );
   end

   lsu_load_align u_load_align (
      .clk         (clk),
      .rst_n       (rst_n),
      .stall       (stall),
      .s1_valid    (s1_valid),
      .s1_ealign   (s1_ealign),
      .s1_size     (s1_size),
      .s1_sign_ext (s1_sign_ext),
      .s1_addr     (s1_addr),
      .rdata       (bank_rdata),
      .resp_valid  (resp_valid),
      .resp_ealign (resp_ealign),
      .resp_vaddr  (resp_vaddr),
      .resp_dout   (resp_dout)
   );

endmodule

`default_nettype wire

// ==== tests/lsu_tb_model.svh ====
//////////////////////////////////////////////////
// Load/store unit testbench model
// Byte array image of the data memory, random
// number source and the expected response rule
//////////////////////////////////////////////////

`ifndef LSU_TB_MODEL_SVH
`define LSU_TB_MODEL_SVH

// One expected response
typedef struct packed {
   logic        ealign;
   logic        chk_data;   // Only aligned loads carry data
   logic [15:0] vaddr;
   logic [31:0] dout;
   logic [31:0] acc;        // Enabled edge count at acceptance
} exp_t;

logic [7:0] model_mem [MODEL_BYTES];

function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

// Applies one request to the model and returns what the unit must answer
function automatic exp_t ref_access(input logic load, input logic store, input logic sign,
                                    input lsu_size_t size, input lsu_addr_t addr,
                                    input lsu_data_t wdata);
   exp_t        e;
   int          a;
   logic        mis;
   logic [7:0]  b;
   logic [15:0] h;
   a   = int'(addr) % MODEL_BYTES;   // Upper address bits alias
   mis = ((size == SIZE_WORD) && (addr[1:0] != 2'b00)) ||
         ((size == SIZE_HALF) && addr[0]);
   e.ealign   = mis;
   e.chk_data = load & ~mis;
   e.vaddr    = addr;
   e.dout     = '0;
   e.acc      = '0;
   if (store && !mis) begin
      model_mem[a] = wdata[7:0];
      if (size != SIZE_BYTE) model_mem[a+1] = wdata[15:8];
      if (size == SIZE_WORD) begin
         model_mem[a+2] = wdata[23:16];
         model_mem[a+3] = wdata[31:24];
      end
   end
   if (load && !mis) begin
      b = model_mem[a];
      h = {model_mem[a+1], model_mem[a]};
      case (size)
         SIZE_BYTE: e.dout = {{24{sign & b[7]}}, b};
         SIZE_HALF: e.dout = {{16{sign & h[15]}}, h};
         default:   e.dout = {model_mem[a+3], model_mem[a+2], h};
      endcase
   end
   return e;
endfunction

`endif

// ==== tests/lsu_tb.sv ====
//////////////////////////////////////////////////
// Load/store unit testbench
// Directed and random loads and stores with stall
// and flush, checked against a byte array model
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_tb;
   import lsu_pkg::*;

   localparam int MEM_WORDS   = 64;
   localparam int MODEL_BYTES = 4 * MEM_WORDS;
   localparam int N_OPS       = 800;   // Bound on issued operations
   localparam int N_RANDOM    = 500;

   logic [31:0] lcg_state = 32'h43b9a05a;

   `include "lsu_tb_model.svh"

   logic clk, rst_n, stall, flush;
   logic req_valid, req_load, req_store, req_sign_ext;
   lsu_size_t req_size;
   lsu_addr_t req_addr;
   lsu_data_t req_wdata;
   logic      resp_valid, resp_ealign;
   lsu_addr_t resp_vaddr;
   lsu_data_t resp_dout;

   exp_t        exp_q [$];
   int          stall_pct = 0;
   int          n_issued = 0;
   int          err_data = 0, err_ctrl = 0, err_order = 0;
   logic [31:0] en_cnt = '0;
   // Mirror of the item held in stage 1
   logic        slot_valid = 1'b0;
   logic        slot_load, slot_store, slot_sign;
   lsu_size_t   slot_size;
   lsu_addr_t   slot_addr;
   lsu_data_t   slot_wdata;
   logic [31:0] slot_acc;

   lsu_top #(.MEM_WORDS(MEM_WORDS)) u_dut (
      .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
      .req_valid(req_valid), .req_load(req_load), .req_store(req_store),
      .req_sign_ext(req_sign_ext), .req_size(req_size), .req_addr(req_addr),
      .req_wdata(req_wdata), .resp_valid(resp_valid), .resp_ealign(resp_ealign),
      .resp_vaddr(resp_vaddr), .resp_dout(resp_dout)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Comparison and stage 1 tracking, one pass per rising edge
   always @(posedge clk) begin
      exp_t e;
      if (rst_n && !stall) begin
         if (resp_valid) begin
            if (exp_q.size() == 0) begin
               $display("Error at %0t: response appeared with nothing expected", $time);
               err_order++;
            end else begin
               e = exp_q.pop_front();
               if (en_cnt != e.acc + 32'd2) begin
                  $display("FAIL %0t: latency, accepted at edge %0d", $time, e.acc);
                  err_order++;
               end
               if (resp_ealign !== e.ealign) begin
                  $display("FAIL %0t: ealign %b, expected %b", $time, resp_ealign, e.ealign);
                  err_ctrl++;
               end
               if (resp_vaddr !== e.vaddr) begin
                  $display("FAIL %0t: vaddr %h, expected %h", $time, resp_vaddr, e.vaddr);
                  err_ctrl++;
               end
               if (e.chk_data && (resp_dout !== e.dout)) begin
                  $display("FAIL %0t: dout %h, expected %h at %h", $time, resp_dout, e.dout,
                           e.vaddr);
                  err_data++;
               end
            end
         end else if (exp_q.size() != 0 && en_cnt >= exp_q[0].acc + 32'd2) begin
            $display("Error at %0t: response for address %h never appeared", $time,
                     exp_q[0].vaddr);
            err_order++;
            e = exp_q.pop_front();
         end
      end
      if (!rst_n) begin
         slot_valid = 1'b0;
      end else if (!stall) begin
         if (slot_valid) begin   // Item leaves stage 1 and commits
            e = ref_access(slot_load, slot_store, slot_sign, slot_size, slot_addr, slot_wdata);
            e.acc = slot_acc;
            exp_q.push_back(e);
         end
         slot_valid = req_valid & ~flush & (req_load | req_store);
         slot_load  = req_load;
         slot_store = req_store;
         slot_sign  = req_sign_ext;
         slot_size  = req_size;
         slot_addr  = req_addr;
         slot_wdata = req_wdata;
         slot_acc   = en_cnt;
         en_cnt     = en_cnt + 32'd1;
      end else if (flush) begin
         slot_valid = 1'b0;   // Held item dropped
      end
   end

   function automatic logic pick_stall();
      return (lcg_next() % 32'd100) < stall_pct;
   endfunction

   // Presents one request until an enabled edge takes it
   task automatic drive_op(input logic load, input logic store, input logic sign,
                           input lsu_size_t size, input lsu_addr_t addr, input lsu_data_t wdata);
      logic held;
      held = 1'b1;
      while (held) begin
         @(negedge clk);
         req_valid    = 1'b1;
         req_load     = load;
         req_store    = store;
         req_sign_ext = sign;
         req_size     = size;
         req_addr     = addr;
         req_wdata    = wdata;
         flush        = 1'b0;
         stall        = pick_stall();
         held         = stall;
      end
      n_issued++;
   endtask

   task automatic store_op(input lsu_size_t size, input lsu_addr_t addr, input lsu_data_t d);
      drive_op(1'b0, 1'b1, 1'b0, size, addr, d);
   endtask

   task automatic load_op(input lsu_size_t size, input logic sign, input lsu_addr_t addr);
      drive_op(1'b1, 1'b0, sign, size, addr, 32'h0);
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge clk);
         req_valid = 1'b0;
         flush     = 1'b0;
         stall     = pick_stall();
      end
   endtask

   // Store sits in stage 1 while frozen, then gets flushed
   task automatic flush_in_stall(input lsu_size_t size, input lsu_addr_t addr,
                                 input lsu_data_t d);
      @(negedge clk);
      req_valid = 1'b1;
      req_load  = 1'b0;
      req_store = 1'b1;
      req_size  = size;
      req_addr  = addr;
      req_wdata = d;
      stall     = 1'b0;
      flush     = 1'b0;
      @(negedge clk);
      req_valid = 1'b0;
      stall     = 1'b1;
      flush     = 1'b1;
      @(negedge clk);
      flush = 1'b0;   // One more frozen cycle
      @(negedge clk);
      stall = 1'b0;
      n_issued++;
   endtask

   // Flush on the accepting edge keeps the store out of stage 1
   task automatic flush_on_entry(input lsu_size_t size, input lsu_addr_t addr,
                                 input lsu_data_t d);
      @(negedge clk);
      req_valid = 1'b1;
      req_load  = 1'b0;
      req_store = 1'b1;
      req_size  = size;
      req_addr  = addr;
      req_wdata = d;
      stall     = 1'b0;
      flush     = 1'b1;
      @(negedge clk);
      req_valid = 1'b0;
      flush     = 1'b0;
      n_issued++;
   endtask

   function automatic lsu_data_t word_pattern(input lsu_addr_t a);
      return {a ^ 16'h5a3c, ~a};
   endfunction

   initial begin
      #(N_OPS * 4 * 4 + 2000);
      $display("Timeout: the run did not finish in time");
      $display("Simulation failed");
      $finish;
   end

   initial begin
      logic [31:0] r;
      lsu_size_t   sz;
      rst_n        = 1'b0;
      stall        = 1'b0;
      flush        = 1'b0;
      req_valid    = 1'b0;
      req_load     = 1'b0;
      req_store    = 1'b0;
      req_sign_ext = 1'b0;
      req_size     = SIZE_WORD;
      req_addr     = '0;
      req_wdata    = '0;
      repeat (2) @(posedge clk);
      @(negedge clk) rst_n = 1'b1;

      // Fill every word, then read all back
      for (int i = 0; i < MEM_WORDS; i++) begin
         store_op(SIZE_WORD, lsu_addr_t'(4*i), word_pattern(lsu_addr_t'(4*i)));
      end
      for (int i = 0; i < MEM_WORDS; i++) load_op(SIZE_WORD, 1'b0, lsu_addr_t'(4*i));

      // Byte and halfword merges at each lane offset
      for (int k = 0; k < 4; k++) begin
         store_op(SIZE_BYTE, lsu_addr_t'(16'h14 + k), 32'h0000_0080 + k);
         load_op(SIZE_BYTE, 1'b1, lsu_addr_t'(16'h14 + k));
         load_op(SIZE_BYTE, 1'b0, lsu_addr_t'(16'h14 + k));
      end
      load_op(SIZE_WORD, 1'b0, 16'h14);
      store_op(SIZE_HALF, 16'h18, 32'h0000_8001);
      store_op(SIZE_HALF, 16'h1a, 32'h0000_7ffe);
      for (int k = 0; k < 2; k++) begin
         load_op(SIZE_HALF, 1'b1, lsu_addr_t'(16'h18 + 2*k));
         load_op(SIZE_HALF, 1'b0, lsu_addr_t'(16'h18 + 2*k));
      end
      load_op(SIZE_WORD, 1'b0, 16'h18);

      // Misaligned accesses leave memory alone
      for (int k = 1; k < 4; k++) store_op(SIZE_WORD, lsu_addr_t'(16'h20 + k), 32'hdead_beef);
      store_op(SIZE_HALF, 16'h25, 32'h0000_1234);
      store_op(SIZE_HALF, 16'h27, 32'h0000_5678);
      load_op(SIZE_WORD, 1'b0, 16'h20);
      load_op(SIZE_WORD, 1'b0, 16'h24);
      load_op(SIZE_WORD, 1'b0, 16'h31);
      load_op(SIZE_HALF, 1'b1, 16'h33);

      // Back-pressure
      stall_pct = 40;
      for (int i = 0; i < 32; i++) begin
         store_op(SIZE_WORD, lsu_addr_t'(16'h100 + 4*i), lcg_next());
         load_op(SIZE_WORD, 1'b0, lsu_addr_t'(16'h100 + 4*i));
         if (i % 4 == 0) idle(2);
      end
      stall_pct = 0;

      // Flushed stores never reach memory
      flush_in_stall(SIZE_WORD, 16'h40, 32'h1111_2222);
      load_op(SIZE_WORD, 1'b0, 16'h40);
      flush_on_entry(SIZE_WORD, 16'h44, 32'h3333_4444);
      load_op(SIZE_WORD, 1'b0, 16'h44);

      // Random mix with aliasing over the whole address range
      stall_pct = 25;
      for (int i = 0; i < N_RANDOM; i++) begin
         r  = lcg_next();
         sz = lsu_size_t'(3'(1 + (r[7:4] % 3)));
         if (r[3:0] == 4'd0) begin
            if (r[8]) flush_in_stall(sz, lsu_addr_t'(lcg_next()), lcg_next());
            else flush_on_entry(sz, lsu_addr_t'(lcg_next()), lcg_next());
         end else if (r[9]) begin
            store_op(sz, lsu_addr_t'(lcg_next()), lcg_next());
         end else begin
            load_op(sz, r[10], lsu_addr_t'(lcg_next()));
         end
      end

      stall_pct = 0;
      idle(1);
      while (exp_q.size() != 0 || slot_valid) @(negedge clk);
      idle(4);
      $display("Summary: %0d operations, data errors %0d, control errors %0d, %s %0d",
               n_issued, err_data, err_ctrl, "ordering errors", err_order);
      if (err_data + err_ctrl + err_order == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
